/* cpu.f */
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/fetch_pc.sv
verilog/hazard_ctrl.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/forward_unit.sv
verilog/word_mem.sv
verilog/cpu.sv
verification/cpu_chk.sv
verification/cpu_tb.sv

/* verification/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb;

	import isa_pkg::*;

	localparam int MEM_WORDS = 256;
	localparam int HALT_WAIT = 2000;

	logic        clk;
	logic        rst;
	logic        imem_we;
	logic [15:0] imem_addr;
	logic [15:0] imem_wdata;
	logic        hlt;
	logic [15:0] pc_out;

	logic [15:0] prog[$];
	int          errors;
	int          checks;
	int          tests;
	integer      seed;

	cpu i_dut (
		.clk(clk), .rst(rst), .imem_we(imem_we), .imem_addr(imem_addr),
		.imem_wdata(imem_wdata), .hlt(hlt), .pc_out(pc_out)
	);

	always #20 clk = ~clk;

	// ----------------------------------------
	// Instruction encoding
	// ----------------------------------------
	function automatic logic [15:0] rtype(logic [3:0] op, logic [3:0] rd,
		logic [3:0] rs, logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic logic [15:0] llb(logic [3:0] rd, logic [7:0] imm);
		return {OP_LLB, rd, imm};
	endfunction

	function automatic logic [15:0] lhb(logic [3:0] rd, logic [7:0] imm);
		return {OP_LHB, rd, imm};
	endfunction

	function automatic logic [15:0] bcc(logic [2:0] cc, logic [8:0] off);
		return {OP_B, cc, off};
	endfunction

	// Unconditional jump through rs
	function automatic logic [15:0] jr(logic [3:0] rs);
		return {OP_BR, 3'b111, 1'b0, rs, 4'h0};
	endfunction

	// HLT everywhere, low bits carry the word index
	function automatic logic [15:0] fill_word(int idx);
		return {4'hF, 12'(idx)};
	endfunction

	function automatic bit cond_holds(logic [2:0] cc, logic z, logic v, logic n);
		case (cc)
			3'b000:  return !z;
			3'b001:  return z;
			3'b010:  return !z && !n;
			3'b011:  return n;
			3'b100:  return z || (!z && !n);
			3'b101:  return z || n;
			3'b110:  return v;
			default: return 1'b1;
		endcase
	endfunction

	// ----------------------------------------
	// Reference model, one instruction per step
	// ----------------------------------------
	task automatic model_run(output logic [15:0] halt_pc, output bit ok);
		logic [15:0] im [MEM_WORDS];
		logic [15:0] dm [MEM_WORDS];
		logic [15:0] rf [16];
		logic [15:0] pc, nxt, w, a, b, res, addr;
		logic        z, v, n;
		logic [3:0]  op, rd, rs, rt;
		for (int i = 0; i < MEM_WORDS; i++) begin
			im[i] = (i < prog.size()) ? prog[i] : fill_word(i);
			dm[i] = '0;
		end
		for (int i = 0; i < 16; i++)
			rf[i] = '0;
		{z, v, n} = 3'b000;
		pc = '0;
		ok = 1'b0;
		halt_pc = '0;
		for (int step = 0; step < 1000; step++) begin
			w = im[(pc >> 1) % MEM_WORDS];
			{op, rd, rs, rt} = w;
			nxt = pc + 16'd2;
			a = rf[rs];
			b = rf[rt];
			case (op)
				4'h0, 4'h1, 4'h2, 4'h4, 4'h5: begin
					case (op)
						4'h0:    res = a + b;
						4'h1:    res = a - b;
						4'h2:    res = a ^ b;
						4'h4:    res = a << rt;
						default: res = $signed(a) >>> rt;
					endcase
					z = (res == 16'd0);
					if (op == 4'h0) begin
						n = res[15];
						v = (a[15] == b[15]) && (res[15] != a[15]);
					end else if (op == 4'h1) begin
						n = res[15];
						v = (a[15] != b[15]) && (res[15] != a[15]);
					end
					if (rd != 0)
						rf[rd] = res;
				end
				4'h8: begin
					addr = {a[15:1], 1'b0} + {{11{rt[3]}}, rt, 1'b0};
					if (rd != 0)
						rf[rd] = dm[(addr >> 1) % MEM_WORDS];
				end
				4'h9: begin
					addr = {rf[rd][15:1], 1'b0} + {{11{rt[3]}}, rt, 1'b0};
					dm[(addr >> 1) % MEM_WORDS] = a;
				end
				4'hA: if (rd != 0) rf[rd] = {w[7:0], rf[rd][7:0]};
				4'hB: if (rd != 0) rf[rd] = {rf[rd][15:8], w[7:0]};
				4'hC: if (cond_holds(w[11:9], z, v, n))
					nxt = pc + 16'd2 + {{6{w[8]}}, w[8:0], 1'b0};
				4'hD: if (cond_holds(w[11:9], z, v, n))
					nxt = {a[15:1], 1'b0};
				4'hF: begin
					halt_pc = pc + 16'd2;
					ok = 1'b1;
					return;
				end
				default: ;
			endcase
			pc = nxt;
		end
	endtask

	// ----------------------------------------
	// DUT sequencing
	// ----------------------------------------
	task automatic check_eq(string what, logic [15:0] got, logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Writes the program while rst is high, reset then lasts 16 more cycles
	task automatic load_program();
		@(posedge clk);
		#2;
		rst = 1'b1;
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem_we    = 1'b1;
			imem_addr  = 16'(i * 2);
			imem_wdata = (i < prog.size()) ? prog[i] : fill_word(i);
			@(posedge clk);
			#2;
		end
		imem_we = 1'b0;
		repeat (16) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic release_reset(string name);
		rst = 1'b0;
		@(posedge clk);
		#2;
		check_eq({name, " hlt after reset"}, {15'd0, hlt}, 16'd0);
	endtask

	task automatic wait_halt(string name, output bit done);
		int cnt;
		cnt = 0;
		while (!hlt && cnt < HALT_WAIT) begin
			@(posedge clk);
			#2;
			cnt++;
		end
		done = hlt;
		if (!done) begin
			errors++;
			$display("%s: timeout, hlt did not rise within %0d cycles", name, HALT_WAIT);
		end
	endtask

	task automatic run_case(string name);
		logic [15:0] exp;
		bit          ok;
		bit          done;
		model_run(exp, ok);
		if (!ok) begin
			errors++;
			$display("%s: reference model never reached an HLT", name);
		end
		load_program();
		release_reset(name);
		wait_halt(name, done);
		if (done && ok)
			check_eq({name, " pc_out"}, pc_out, exp);
	endtask

	// Two runs expose low then high byte of res through the landing address
	task automatic run_result(string name, logic [3:0] res);
		logic [15:0] base[$];
		base = prog;
		prog.push_back(rtype(OP_ADD, 4'd15, res, 4'd0));
		prog.push_back(lhb(4'd15, 8'h01));
		prog.push_back(jr(4'd15));
		run_case({name, " low"});
		prog = base;
		prog.push_back(rtype(OP_SRA, 4'd15, res, 4'd8));
		prog.push_back(lhb(4'd15, 8'h01));
		prog.push_back(jr(4'd15));
		run_case({name, " high"});
		prog = base;
	endtask

	task automatic report(string name, int start_err);
		tests++;
		$display("test %s: %0d errors", name, errors - start_err);
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------
	task automatic alu_chain_prog();
		prog = {};
		prog.push_back(llb(4'd1, 8'h34));
		prog.push_back(lhb(4'd1, 8'h92));
		prog.push_back(llb(4'd2, 8'h0F));
		prog.push_back(rtype(OP_ADD, 4'd3, 4'd1, 4'd2));
		prog.push_back(rtype(OP_SUB, 4'd4, 4'd3, 4'd1));
		prog.push_back(rtype(OP_XOR, 4'd5, 4'd4, 4'd3));
		prog.push_back(rtype(OP_SLL, 4'd6, 4'd5, 4'd3));
		prog.push_back(rtype(OP_SRA, 4'd7, 4'd1, 4'd2));
		prog.push_back(rtype(OP_ADD, 4'd8, 4'd7, 4'd6));
		prog.push_back(rtype(OP_XOR, 4'd9, 4'd8, 4'd5));
		prog.push_back(rtype(OP_SUB, 4'd9, 4'd9, 4'd7));
	endtask

	task automatic test_alu();
		int e0;
		e0 = errors;
		alu_chain_prog();
		run_result("alu", 4'd9);
		report("alu", e0);
	endtask

	task automatic test_mem();
		int e0;
		e0 = errors;
		prog = {};
		prog.push_back(llb(4'd1, 8'h40));
		prog.push_back(llb(4'd2, 8'h55));
		prog.push_back(lhb(4'd2, 8'hAA));
		prog.push_back(rtype(OP_SW, 4'd1, 4'd2, 4'd0));
		prog.push_back(llb(4'd3, 8'h77));
		prog.push_back(rtype(OP_SW, 4'd1, 4'd3, 4'd1));
		prog.push_back(rtype(OP_LW, 4'd4, 4'd1, 4'd0));
		prog.push_back(rtype(OP_ADD, 4'd5, 4'd4, 4'd4));
		prog.push_back(rtype(OP_LW, 4'd6, 4'd1, 4'd1));
		prog.push_back(rtype(OP_XOR, 4'd7, 4'd6, 4'd5));
		prog.push_back(rtype(OP_LW, 4'd8, 4'd1, 4'd1));
		prog.push_back(rtype(OP_SW, 4'd1, 4'd8, 4'd2));
		prog.push_back(rtype(OP_LW, 4'd9, 4'd1, 4'd2));
		prog.push_back(rtype(OP_LW, 4'd10, 4'd1, 4'hF));
		prog.push_back(rtype(OP_ADD, 4'd11, 4'd9, 4'd7));
		prog.push_back(rtype(OP_ADD, 4'd11, 4'd11, 4'd10));
		run_result("mem", 4'd11);
		report("mem", e0);
	endtask

	// Flag setter by kind: zero, positive, negative, overflow
	function automatic logic [15:0] setter(int kind);
		case (kind)
			0:       return rtype(OP_SUB, 4'd5, 4'd2, 4'd2);
			1:       return rtype(OP_ADD, 4'd5, 4'd2, 4'd2);
			2:       return rtype(OP_SUB, 4'd5, 4'd3, 4'd2);
			default: return rtype(OP_ADD, 4'd5, 4'd1, 4'd2);
		endcase
	endfunction

	task automatic test_branch();
		int e0;
		int kinds_a[8] = '{1, 0, 1, 2, 0, 2, 3, 1};
		int kinds_b[8] = '{0, 1, 0, 1, 2, 1, 1, 0};
		e0 = errors;
		prog = {};
		prog.push_back(llb(4'd1, 8'hFF));
		prog.push_back(lhb(4'd1, 8'h7F));
		prog.push_back(llb(4'd2, 8'h01));
		for (int c = 0; c < 8; c++) begin
			for (int k = 0; k < 2; k++) begin
				prog.push_back(llb(4'd11, 8'(c * 37 + k * 11 + 3)));
				prog.push_back(setter(k == 0 ? kinds_a[c] : kinds_b[c]));
				prog.push_back(bcc(3'(c), 9'd1));
				// Skipped when taken
				prog.push_back(rtype(OP_ADD, 4'd10, 4'd10, 4'd11));
			end
		end
		run_result("branch", 4'd10);
		report("branch", e0);
	endtask

	task automatic test_halt();
		int e0;
		e0 = errors;
		prog = {};
		for (int i = 0; i < 5; i++)
			prog.push_back(llb(4'(i + 1), 8'(i)));
		prog.push_back({OP_HLT, 12'h000});
		run_case("halt at 10");
		check_eq("halt address", pc_out, 16'd12);
		// HLTs in the shadow of a taken branch
		prog = {};
		prog.push_back(llb(4'd1, 8'h21));
		prog.push_back(bcc(3'b111, 9'd2));
		prog.push_back({OP_HLT, 12'h000});
		prog.push_back({OP_HLT, 12'h000});
		prog.push_back(llb(4'd2, 8'h5A));
		prog.push_back(rtype(OP_ADD, 4'd3, 4'd2, 4'd1));
		run_result("halt shadow", 4'd3);
		report("halt", e0);
	endtask

	task automatic test_random();
		int          e0;
		logic [15:0] a;
		logic [15:0] b;
		logic [3:0]  op;
		e0 = errors;
		for (int i = 0; i < 20; i++) begin
			a = $random(seed);
			b = $random(seed);
			case ($unsigned($random(seed)) % 3)
				0:       op = OP_ADD;
				1:       op = OP_SUB;
				default: op = OP_XOR;
			endcase
			prog = {};
			prog.push_back(llb(4'd1, a[7:0]));
			prog.push_back(lhb(4'd1, a[15:8]));
			prog.push_back(llb(4'd2, b[7:0]));
			prog.push_back(lhb(4'd2, b[15:8]));
			prog.push_back(rtype(op, 4'd3, 4'd1, 4'd2));
			run_result($sformatf("random %0d", i), 4'd3);
		end
		report("random", e0);
	endtask

	task automatic test_reset();
		int  e0;
		bit  done;
		logic [15:0] exp;
		bit  ok;
		e0 = errors;
		alu_chain_prog();
		prog.push_back(rtype(OP_ADD, 4'd15, 4'd9, 4'd0));
		prog.push_back(lhb(4'd15, 8'h01));
		prog.push_back(jr(4'd15));
		model_run(exp, ok);
		load_program();
		release_reset("reset");
		repeat (6) begin
			@(posedge clk);
			#2;
		end
		// Interrupt mid-program
		rst = 1'b1;
		repeat (16) begin
			@(posedge clk);
			#2;
		end
		check_eq("reset hlt", {15'd0, hlt}, 16'd0);
		check_eq("reset pc_out", pc_out, 16'd0);
		release_reset("rerun");
		wait_halt("reset rerun", done);
		if (done && ok)
			check_eq("reset rerun pc_out", pc_out, exp);
		report("reset", e0);
	endtask

	initial begin
		clk        = 1'b0;
		rst        = 1'b1;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = '0;
		errors     = 0;
		checks     = 0;
		tests      = 0;
		seed       = 67;

		test_alu();
		test_mem();
		test_branch();
		test_halt();
		test_random();
		test_reset();

		errors += i_dut.i_chk.fail_count;
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* verification/cpu_chk.sv */
`timescale 1ns/1ns

module cpu_chk (
	input logic                clk,
	input logic                rst,
	input logic                hlt,
	input logic [15:0]         pc_out,
	input pipe_pkg::hz_state_t state
);

	import pipe_pkg::*;

	// Failed assertions so far
	int fail_count = 0;

	// Reset always lands in RUN
	a_hlt_low_after_rst: assert property (@(posedge clk) rst |=> !hlt)
		else begin
			$error("hlt high in the cycle after reset");
			fail_count++;
		end

	// Only reset leaves HALTED
	a_hlt_sticky: assert property (@(posedge clk) disable iff (rst) hlt |=> hlt)
		else begin
			$error("hlt fell without reset");
			fail_count++;
		end

	// Fetch address frozen from DRAIN_EX through HALTED
	a_pc_frozen: assert property (@(posedge clk) disable iff (rst)
		(state != RUN) |-> $stable(pc_out))
		else begin
			$error("pc_out moved while halting");
			fail_count++;
		end

endmodule

bind cpu cpu_chk i_chk (
	.clk(clk), .rst(rst), .hlt(hlt), .pc_out(pc_out), .state(i_hazard.state)
);

/* verilog/cpu.sv */
`timescale 1ns/1ns

module cpu #(
	parameter int IMEM_DEPTH = 256,
	parameter int DMEM_DEPTH = 256
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        imem_we,
	input  logic [15:0] imem_addr,
	input  logic [15:0] imem_wdata,
	output logic        hlt,
	output logic [15:0] pc_out
);

	import isa_pkg::*;
	import pipe_pkg::*;

	// Hazard controls
	logic stall, flush, hold_fetch;

	// Fetch
	logic [15:0] imem_a, imem_rdata;

	// Decode
	instr_t                id_instr;
	logic [15:0]           id_pc2, id_rdata1, id_rdata2;
	logic [REG_ADDR_W-1:0] id_rs1, id_rs2;
	logic                  id_valid, id_reg_we, id_mem_to_reg, id_mem_we;

	// Execute
	instr_t                ex_instr;
	logic [15:0]           ex_pc2, ex_rdata1, ex_rdata2;
	logic [REG_ADDR_W-1:0] ex_rs1, ex_rs2, ex_rd;
	logic                  ex_valid, ex_reg_we, ex_mem_to_reg, ex_mem_we;
	fwd_sel_t              sel_a, sel_b;
	logic [15:0]           alu_a, src_b, alu_b, alu_result, ex_result, ex_addr;
	logic [FLAG_W-1:0]     alu_flags, alu_flag_we;
	logic                  is_shift, branch_taken;
	logic [15:0]           branch_target;

	// Memory
	logic [15:0]           mem_result, mem_addr, mem_wdata, dmem_rdata;
	logic [REG_ADDR_W-1:0] mem_rd;
	logic                  mem_reg_we, mem_mem_to_reg, mem_mem_we;

	// Writeback
	logic [15:0]           wb_result, wb_load, wb_data;
	logic [REG_ADDR_W-1:0] wb_rd;
	logic                  wb_reg_we, wb_mem_to_reg;

	// ----------------------------------------
	// Fetch
	// ----------------------------------------
	// Load port owns the address while writing
	assign imem_a = imem_we ? imem_addr : pc_out;

	fetch_pc i_fetch_pc (
		.clk(clk), .rst(rst), .hold(hold_fetch), .load(flush),
		.target(branch_target), .pc(pc_out)
	);

	word_mem #(.DEPTH(IMEM_DEPTH), .CLEAR(1'b0)) i_imem (
		.clk(clk), .rst(rst), .addr(imem_a), .wdata(imem_wdata),
		.we(imem_we), .rdata(imem_rdata)
	);

	// IF/ID, NOP on flush and through the halt drain
	always_ff @(posedge clk) begin
		if (rst || flush || (hold_fetch && !stall)) begin
			id_instr <= NOP_WORD;
			id_valid <= 1'b0;
		end else if (!stall) begin
			id_instr <= imem_rdata;
			id_pc2   <= pc_out + 16'd2;
			id_valid <= 1'b1;
		end
	end

	// ----------------------------------------
	// Decode
	// ----------------------------------------
	assign id_rs1 = src1_of(id_instr);
	assign id_rs2 = src2_of(id_instr);

	// Bubbles carry no control
	always_comb begin
		id_reg_we     = 1'b0;
		id_mem_to_reg = 1'b0;
		id_mem_we     = 1'b0;
		case (id_instr.r.opcode)
			OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRA, OP_LLB, OP_LHB: begin
				id_reg_we = id_valid;
			end
			OP_LW: begin
				id_reg_we     = id_valid;
				id_mem_to_reg = id_valid;
			end
			OP_SW: begin
				id_mem_we = id_valid;
			end
			default: ;
		endcase
	end

	reg_file i_reg_file (
		.clk(clk), .rst(rst), .rs1(id_rs1), .rs2(id_rs2), .rd(wb_rd),
		.we(wb_reg_we), .wdata(wb_data), .rdata1(id_rdata1), .rdata2(id_rdata2)
	);

	hazard_ctrl i_hazard (
		.clk(clk), .rst(rst), .id_instr(id_instr), .ex_is_load(ex_mem_to_reg),
		.ex_rd(ex_rd), .branch_taken(branch_taken), .stall(stall), .flush(flush),
		.hold_fetch(hold_fetch), .hlt(hlt)
	);

	// ID/EX, bubble on stall or flush
	always_ff @(posedge clk) begin
		if (rst || flush || stall) begin
			ex_instr      <= NOP_WORD;
			ex_rs1        <= '0;
			ex_rs2        <= '0;
			ex_rd         <= '0;
			ex_valid      <= 1'b0;
			ex_reg_we     <= 1'b0;
			ex_mem_to_reg <= 1'b0;
			ex_mem_we     <= 1'b0;
		end else begin
			ex_instr      <= id_instr;
			ex_pc2        <= id_pc2;
			ex_rdata1     <= id_rdata1;
			ex_rdata2     <= id_rdata2;
			ex_rs1        <= id_rs1;
			ex_rs2        <= id_rs2;
			ex_rd         <= id_instr.r.rd;
			ex_valid      <= id_valid;
			ex_reg_we     <= id_reg_we;
			ex_mem_to_reg <= id_mem_to_reg;
			ex_mem_we     <= id_mem_we;
		end
	end

	// ----------------------------------------
	// Execute
	// ----------------------------------------
	forward_unit i_forward (
		.ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .mem_rd(mem_rd), .wb_rd(wb_rd),
		.mem_we(mem_reg_we), .wb_we(wb_reg_we), .sel_a(sel_a), .sel_b(sel_b)
	);

	assign alu_a = (sel_a == FWD_MEM) ? mem_result : (sel_a == FWD_WB) ? wb_data : ex_rdata1;
	assign src_b = (sel_b == FWD_MEM) ? mem_result : (sel_b == FWD_WB) ? wb_data : ex_rdata2;

	// Shifts take imm4
	assign is_shift = (ex_instr.r.opcode == OP_SLL) || (ex_instr.r.opcode == OP_SRA);
	assign alu_b    = is_shift ? {12'd0, ex_instr.r.rt} : src_b;

	alu i_alu (
		.a(alu_a), .b(alu_b), .op(ex_instr.r.opcode), .result(alu_result),
		.flags(alu_flags), .flag_we(alu_flag_we)
	);

	// Byte merge, imm8 is rs:rt
	always_comb begin
		case (ex_instr.r.opcode)
			OP_LLB:  ex_result = {alu_a[15:8], ex_instr.r.rs, ex_instr.r.rt};
			OP_LHB:  ex_result = {ex_instr.r.rs, ex_instr.r.rt, alu_a[7:0]};
			default: ex_result = alu_result;
		endcase
	end

	// Word-aligned base plus imm4 words
	assign ex_addr = {alu_a[15:1], 1'b0} + {{11{ex_instr.r.rt[3]}}, ex_instr.r.rt, 1'b0};

	branch_unit i_branch (
		.clk(clk), .rst(rst), .flush(flush), .instr(ex_instr), .pc_next(ex_pc2),
		.reg_val(alu_a), .flags_in(alu_flags), .flag_we(alu_flag_we & {FLAG_W{ex_valid}}),
		.taken(branch_taken), .target(branch_target)
	);

	// EX/MEM
	always_ff @(posedge clk) begin
		mem_result <= ex_result;
		mem_addr   <= ex_addr;
		mem_wdata  <= src_b;
		mem_rd     <= ex_rd;
		if (rst) begin
			mem_reg_we     <= 1'b0;
			mem_mem_to_reg <= 1'b0;
			mem_mem_we     <= 1'b0;
		end else begin
			mem_reg_we     <= ex_reg_we;
			mem_mem_to_reg <= ex_mem_to_reg;
			mem_mem_we     <= ex_mem_we;
		end
	end

	// ----------------------------------------
	// Memory and writeback
	// ----------------------------------------
	word_mem #(.DEPTH(DMEM_DEPTH), .CLEAR(1'b1)) i_dmem (
		.clk(clk), .rst(rst), .addr(mem_addr), .wdata(mem_wdata),
		.we(mem_mem_we), .rdata(dmem_rdata)
	);

	// MEM/WB
	always_ff @(posedge clk) begin
		wb_result <= mem_result;
		wb_load   <= dmem_rdata;
		wb_rd     <= mem_rd;
		if (rst) begin
			wb_reg_we     <= 1'b0;
			wb_mem_to_reg <= 1'b0;
		end else begin
			wb_reg_we     <= mem_reg_we;
			wb_mem_to_reg <= mem_mem_to_reg;
		end
	end

	// Load data or execute result
	assign wb_data = wb_mem_to_reg ? wb_load : wb_result;

endmodule

/* verilog/word_mem.sv */
`timescale 1ns/1ns

module word_mem #(
	parameter int DEPTH = 256,
	parameter bit CLEAR = 1'b1
) (
	input  logic        clk,
	input  logic        rst,
	input  logic [15:0] addr,
	input  logic [15:0] wdata,
	input  logic        we,
	output logic [15:0] rdata
);

	localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [15:0]      mem [DEPTH];
	logic [IDX_W-1:0] idx;

	// Byte address to word index, wraps at DEPTH
	assign idx   = IDX_W'(32'(addr[15:1]) % DEPTH);
	assign rdata = mem[idx];

	// Instruction store keeps its contents through reset
	always_ff @(posedge clk) begin
		if (CLEAR && rst) begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;
		end else if (we) begin
			mem[idx] <= wdata;
		end
	end

endmodule

/* verilog/forward_unit.sv */
`timescale 1ns/1ns

module forward_unit (
	input  logic [isa_pkg::REG_ADDR_W-1:0] ex_rs1,
	input  logic [isa_pkg::REG_ADDR_W-1:0] ex_rs2,
	input  logic [isa_pkg::REG_ADDR_W-1:0] mem_rd,
	input  logic [isa_pkg::REG_ADDR_W-1:0] wb_rd,
	input  logic                           mem_we,
	input  logic                           wb_we,
	output pipe_pkg::fwd_sel_t             sel_a,
	output pipe_pkg::fwd_sel_t             sel_b
);

	import isa_pkg::*;
	import pipe_pkg::*;

	// Youngest producer wins, r0 never forwards
	function automatic fwd_sel_t pick(logic [REG_ADDR_W-1:0] src,
		logic [REG_ADDR_W-1:0] m_rd, logic m_we,
		logic [REG_ADDR_W-1:0] w_rd, logic w_we);
		if (m_we && (m_rd != '0) && (m_rd == src))
			return FWD_MEM;
		if (w_we && (w_rd != '0) && (w_rd == src))
			return FWD_WB;
		return FWD_RF;
	endfunction

	// ex_rs2 is r0 when the instruction reads no second register
	assign sel_a = pick(ex_rs1, mem_rd, mem_we, wb_rd, wb_we);
	assign sel_b = pick(ex_rs2, mem_rd, mem_we, wb_rd, wb_we);

endmodule

/* verilog/branch_unit.sv */
`timescale 1ns/1ns

module branch_unit (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       flush,
	input  isa_pkg::instr_t            instr,
	input  logic [15:0]                pc_next,
	input  logic [15:0]                reg_val,
	input  logic [isa_pkg::FLAG_W-1:0] flags_in,
	input  logic [isa_pkg::FLAG_W-1:0] flag_we,
	output logic                       taken,
	output logic [15:0]                target
);

	import isa_pkg::*;

	logic [FLAG_W-1:0] flags;
	logic              z;
	logic              v;
	logic              n;
	logic              cond_met;
	logic              is_br;

	// Per-bit flag update, none from a squashed slot
	always_ff @(posedge clk) begin
		if (rst)
			flags <= '0;
		else if (!flush)
			flags <= (flags & ~flag_we) | (flags_in & flag_we);
	end

	assign z = flags[FLAG_Z];
	assign v = flags[FLAG_V];
	assign n = flags[FLAG_N];

	always_comb begin
		case (instr.b.cond)
			CC_NE:   cond_met = !z;
			CC_EQ:   cond_met = z;
			CC_GT:   cond_met = !z && !n;
			CC_LT:   cond_met = n;
			CC_GE:   cond_met = z || !n;
			CC_LE:   cond_met = z || n;
			CC_OV:   cond_met = v;
			default: cond_met = 1'b1;
		endcase
	end

	// BR shares the condition field with B
	assign is_br = (instr.r.opcode == OP_BR);
	assign taken = ((instr.b.opcode == OP_B) || is_br) && cond_met;

	// Offset counts words
	assign target = is_br ? {reg_val[15:1], 1'b0} :
		pc_next + {{6{instr.b.offset[8]}}, instr.b.offset, 1'b0};

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ns

module alu (
	input  logic [15:0]                a,
	input  logic [15:0]                b,
	input  isa_pkg::opcode_t           op,
	output logic [15:0]                result,
	output logic [isa_pkg::FLAG_W-1:0] flags,
	output logic [isa_pkg::FLAG_W-1:0] flag_we
);

	import isa_pkg::*;

	logic        is_sub;
	logic [15:0] b_eff;
	logic [15:0] sum;
	logic        ovfl;

	// Shared adder, SUB as a + ~b + 1
	assign is_sub = (op == OP_SUB);
	assign b_eff  = is_sub ? ~b : b;
	assign sum    = a + b_eff + {15'd0, is_sub};

	// Same-sign inputs, other-sign sum
	assign ovfl = (a[15] == b_eff[15]) && (sum[15] != a[15]);

	always_comb begin
		result  = sum;
		flag_we = '0;
		case (op)
			OP_ADD, OP_SUB: begin
				flag_we = '1;
			end
			OP_XOR: begin
				result          = a ^ b;
				flag_we[FLAG_Z] = 1'b1;
			end
			// Shift amount is imm4
			OP_SLL: begin
				result          = a << b[3:0];
				flag_we[FLAG_Z] = 1'b1;
			end
			OP_SRA: begin
				result          = $signed(a) >>> b[3:0];
				flag_we[FLAG_Z] = 1'b1;
			end
			default: ;
		endcase
	end

	assign flags[FLAG_Z] = (result == '0);
	assign flags[FLAG_V] = ovfl;
	assign flags[FLAG_N] = result[15];

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [isa_pkg::REG_ADDR_W-1:0] rs1,
	input  logic [isa_pkg::REG_ADDR_W-1:0] rs2,
	input  logic [isa_pkg::REG_ADDR_W-1:0] rd,
	input  logic                           we,
	input  logic [15:0]                    wdata,
	output logic [15:0]                    rdata1,
	output logic [15:0]                    rdata2
);

	import isa_pkg::*;

	logic [15:0] regs [2**REG_ADDR_W];

	// r0 is never written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**REG_ADDR_W; i++)
				regs[i] <= '0;
		end else if (we && (rd != '0)) begin
			regs[rd] <= wdata;
		end
	end

	// Same-cycle write shows through to decode
	assign rdata1 = (rs1 == '0) ? '0 :
		(we && (rd == rs1)) ? wdata : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 :
		(we && (rd == rs2)) ? wdata : regs[rs2];

endmodule

/* verilog/hazard_ctrl.sv */
`timescale 1ns/1ns

module hazard_ctrl (
	input  logic                           clk,
	input  logic                           rst,
	input  isa_pkg::instr_t                id_instr,
	input  logic                           ex_is_load,
	input  logic [isa_pkg::REG_ADDR_W-1:0] ex_rd,
	input  logic                           branch_taken,
	output logic                           stall,
	output logic                           flush,
	output logic                           hold_fetch,
	output logic                           hlt
);

	import isa_pkg::*;
	import pipe_pkg::*;

	hz_state_t state;
	logic      id_uses_ex_rd;
	logic      halt_seen;

	// ----------------------------------------
	// Load-use detection
	// ----------------------------------------
	// Unused sources come back as r0, which never matches
	assign id_uses_ex_rd = (ex_rd != '0) &&
		((src1_of(id_instr) == ex_rd) || (src2_of(id_instr) == ex_rd));
	assign stall = ex_is_load && id_uses_ex_rd;

	// Taken branch squashes decode and fetch
	assign flush = branch_taken;

	// HLT in decode, unless it sits in a branch shadow
	assign halt_seen = (state == RUN) && (id_instr.r.opcode == OP_HLT) && !branch_taken;

	// Fetch freezes at HLT + 2 from here on
	assign hold_fetch = stall || halt_seen || (state != RUN);
	assign hlt        = (state == HALTED);

	// ----------------------------------------
	// Halt drain
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= RUN;
		end else begin
			case (state)
				RUN:      if (halt_seen) state <= DRAIN_EX;
				// HLT in execute
				DRAIN_EX: state <= DRAIN_WB;
				// Last older instruction writes back here
				DRAIN_WB: state <= HALTED;
				default:  state <= HALTED;
			endcase
		end
	end

endmodule

/* verilog/fetch_pc.sv */
`timescale 1ns/1ns

module fetch_pc (
	input  logic        clk,
	input  logic        rst,
	input  logic        hold,
	input  logic        load,
	input  logic [15:0] target,
	output logic [15:0] pc
);

	// Branch target wins over a held fetch
	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else if (load)
			pc <= target;
		else if (!hold)
			// Next word
			pc <= pc + 16'd2;
	end

endmodule

/* verilog/pipe_pkg.sv */
package pipe_pkg;

	// ALU operand source
	typedef enum logic [1:0] {
		FWD_RF  = 2'b00,
		FWD_MEM = 2'b01,
		FWD_WB  = 2'b10
	} fwd_sel_t;

	// Halt drain sequence
	typedef enum logic [2:0] {
		RUN      = 3'd0,
		DRAIN_EX = 3'd1,
		DRAIN_WB = 3'd2,
		HALTED   = 3'd3
	} hz_state_t;

endpackage

/* verilog/isa_pkg.sv */
package isa_pkg;

	// Register index and flag widths
	localparam int REG_ADDR_W = 4;
	localparam int FLAG_W     = 3;

	// Flag bit positions, Z/V/N from high to low
	localparam int FLAG_Z = 2;
	localparam int FLAG_V = 1;
	localparam int FLAG_N = 0;

	typedef enum logic [3:0] {
		OP_ADD = 4'b0000,
		OP_SUB = 4'b0001,
		OP_XOR = 4'b0010,
		OP_SLL = 4'b0100,
		OP_SRA = 4'b0101,
		OP_LW  = 4'b1000,
		OP_SW  = 4'b1001,
		OP_LHB = 4'b1010,
		OP_LLB = 4'b1011,
		OP_B   = 4'b1100,
		OP_BR  = 4'b1101,
		OP_HLT = 4'b1111
	} opcode_t;

	typedef enum logic [2:0] {
		CC_NE = 3'b000,
		CC_EQ = 3'b001,
		CC_GT = 3'b010,
		CC_LT = 3'b011,
		CC_GE = 3'b100,
		CC_LE = 3'b101,
		CC_OV = 3'b110,
		CC_UN = 3'b111
	} cond_t;

	// Register view, rt doubles as imm4
	typedef struct packed {
		opcode_t                opcode;
		logic [REG_ADDR_W-1:0]  rd;
		logic [REG_ADDR_W-1:0]  rs;
		logic [REG_ADDR_W-1:0]  rt;
	} reg_view_t;

	// Branch view
	typedef struct packed {
		opcode_t    opcode;
		cond_t      cond;
		logic [8:0] offset;
	} br_view_t;

	typedef union packed {
		reg_view_t r;
		br_view_t  b;
	} instr_t;

	// ADD r0, r0, r0
	localparam logic [15:0] NOP_WORD = 16'h0000;

	// First read register, zero when nothing is read
	function automatic logic [REG_ADDR_W-1:0] src1_of(instr_t i);
		case (i.r.opcode)
			OP_SW, OP_LLB, OP_LHB: return i.r.rd;
			OP_B, OP_HLT:          return '0;
			default:               return i.r.rs;
		endcase
	endfunction

	// Second read register, zero when nothing is read
	function automatic logic [REG_ADDR_W-1:0] src2_of(instr_t i);
		case (i.r.opcode)
			OP_ADD, OP_SUB, OP_XOR: return i.r.rt;
			// Store data sits in rs
			OP_SW:                  return i.r.rs;
			default:                return '0;
		endcase
	endfunction

endpackage
